//--- sources.f
alu_pkg.sv
op_fifo.sv
apb_cmd_port.sv
alu_exec.sv
alu_queue_top.sv
tb_alu_queue.sv

//--- Bender.yml
package:
  name: alu_queue

sources:
  - alu_pkg.sv
  - op_fifo.sv
  - apb_cmd_port.sv
  - alu_exec.sv
  - alu_queue_top.sv
  - target: test
    files:
      - tb_alu_queue.sv

//--- tb_alu_queue.sv
// testbench for the APB operation queue
// drives APB transfers, predicts results with a reference model and checks them in order
`timescale 1ns/1ps

module tb_alu_queue;

  // test 2 dominates: 14 opcodes x 26 operations x about 12 cycles, doubled
  localparam int MAX_CYCLES = 2 * (14 * 26 * 12 + 400);

  logic                         clk;
  logic                         rst_n;
  logic                         psel;
  logic                         penable;
  logic                         pwrite;
  logic [alu_pkg::ADDR_W-1:0]   paddr;
  logic [alu_pkg::DATA_W-1:0]   pwdata;
  logic [alu_pkg::DATA_W-1:0]   prdata;
  logic                         pready;
  logic                         pslverr;

  logic [alu_pkg::DATA_W-1:0]   exp_q[$];
  logic [alu_pkg::DATA_W-1:0]   got_q[$];
  event                         result_read;
  int                           errors;
  int                           tests_failed;
  int                           cycle_count;

  alu_queue_top dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin : watchdog
    wait (cycle_count >= MAX_CYCLES);
    $display("run stopped after %0d cycles without finishing", cycle_count);
    $display("Some tests failed");
    $finish;
  end

  // expected value straight from the operator rules
  function automatic logic [alu_pkg::DATA_W-1:0] alu_ref(alu_pkg::alu_op_e op,
      logic [alu_pkg::DATA_W-1:0] a, logic [alu_pkg::DATA_W-1:0] b);
    logic [alu_pkg::DATA_W-1:0] r;
    r = '0;
    case (op)
      alu_pkg::OP_AND: r = a & b;
      alu_pkg::OP_OR:  r = a | b;
      alu_pkg::OP_XOR: r = a ^ b;
      alu_pkg::OP_NOT: r = ~a;
      alu_pkg::OP_SUB: r = a + ~b + 1;
      alu_pkg::OP_LSH: r = (b >= 32) ? '0 : a << b[4:0];
      alu_pkg::OP_RSH: r = (b >= 32) ? '0 : a >> b[4:0];
      alu_pkg::OP_EQ:  r[0] = (a == b);
      alu_pkg::OP_NEQ: r[0] = (a != b);
      alu_pkg::OP_LT:  r[0] = (a < b);
      alu_pkg::OP_GT:  r[0] = (b < a);
      alu_pkg::OP_LE:  r[0] = !(b < a);
      alu_pkg::OP_GE:  r[0] = !(a < b);
      alu_pkg::OP_CAT: r = {a[15:0], b[15:0]};
      default:         r = '0;
    endcase
    return r;
  endfunction

  task automatic check_data(string name, logic [alu_pkg::DATA_W-1:0] got,
      logic [alu_pkg::DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // one setup plus one access cycle, entered and left 1 ns after an edge
  task automatic apb_xfer(input logic wr, input logic [alu_pkg::ADDR_W-1:0] addr,
      input logic [alu_pkg::DATA_W-1:0] wdata, output logic [alu_pkg::DATA_W-1:0] rdata,
      output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1 penable = 1'b1;
    #2;                            // sampled 1 ns before the access edge
    rdata = prdata;
    err   = pslverr;
    check_flag("pready", pready, 1'b1);
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [alu_pkg::ADDR_W-1:0] addr,
      input logic [alu_pkg::DATA_W-1:0] wdata, output logic err);
    logic [alu_pkg::DATA_W-1:0] unused;
    apb_xfer(1'b1, addr, wdata, unused, err);
  endtask

  task automatic apb_read(input logic [alu_pkg::ADDR_W-1:0] addr,
      output logic [alu_pkg::DATA_W-1:0] rdata, output logic err);
    apb_xfer(1'b0, addr, '0, rdata, err);
  endtask

  task automatic load_operands(logic [alu_pkg::DATA_W-1:0] a, logic [alu_pkg::DATA_W-1:0] b);
    logic err;
    apb_write(alu_pkg::REG_LEFT, a, err);
    check_flag("pslverr", err, 1'b0);
    apb_write(alu_pkg::REG_RIGHT, b, err);
    check_flag("pslverr", err, 1'b0);
  endtask

  task automatic issue_cmd(alu_pkg::alu_op_e op, logic [alu_pkg::DATA_W-1:0] a,
      logic [alu_pkg::DATA_W-1:0] b);
    logic err;
    apb_write(alu_pkg::REG_CMD, {28'd0, op}, err);
    check_flag("pslverr", err, 1'b0);
    if (!err) exp_q.push_back(alu_ref(op, a, b));
  endtask

  task automatic wait_status_bit(int bit_idx, logic level);
    logic [alu_pkg::DATA_W-1:0] st;
    logic                       err;
    do begin
      apb_read(alu_pkg::REG_STATUS, st, err);
    end while (st[bit_idx] !== level);
  endtask

  task automatic read_result();
    logic [alu_pkg::DATA_W-1:0] data;
    logic                       err;
    wait_status_bit(1, 1'b0);      // res_empty low
    apb_read(alu_pkg::REG_RESULT, data, err);
    check_flag("pslverr", err, 1'b0);
    got_q.push_back(data);
    -> result_read;
  endtask

  task automatic run_op(alu_pkg::alu_op_e op, logic [alu_pkg::DATA_W-1:0] a,
      logic [alu_pkg::DATA_W-1:0] b);
    load_operands(a, b);
    issue_cmd(op, a, b);
    read_result();
  endtask

  task automatic report_test(string name, int errs_before);
    if (errors != errs_before) tests_failed++;
    $display("test %s: %s (%0d errors)", name, (errors == errs_before) ? "ok" : "failed",
             errors - errs_before);
  endtask

  // results come back in command order
  initial begin : compare_results
    logic [alu_pkg::DATA_W-1:0] got;
    forever begin
      @(result_read);
      while (got_q.size() != 0) begin
        got = got_q.pop_front();
        if (exp_q.size() == 0) begin
          $display("result %h was read but no command was outstanding", got);
          errors++;
        end else begin
          check_data("prdata", got, exp_q.pop_front());
        end
      end
    end
  end

  initial begin : main
    logic [alu_pkg::DATA_W-1:0] data;
    logic [alu_pkg::DATA_W-1:0] a;
    logic [alu_pkg::DATA_W-1:0] b;
    logic                       err;
    alu_pkg::alu_op_e           op;
    int                         start;
    errors       = 0;
    tests_failed = 0;
    cycle_count  = 0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    void'($urandom(32'hf73c520d));
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;

    start = errors;
    apb_read(alu_pkg::REG_STATUS, data, err);
    check_flag("pslverr", err, 1'b0);
    check_flag("status.cmd_full", data[0], 1'b0);
    check_flag("status.res_empty", data[1], 1'b1);
    check_data("status.count", {29'd0, data[6:4]}, '0);
    apb_read(alu_pkg::REG_LEFT, data, err);
    check_data("left", data, '0);
    apb_read(alu_pkg::REG_RIGHT, data, err);
    check_data("right", data, '0);
    report_test("reset state", start);

    start = errors;
    for (int k = 0; k <= int'(alu_pkg::OP_CAT); k++) begin
      op = alu_pkg::alu_op_e'(k);
      run_op(op, '0, '0);
      run_op(op, '1, '1);
      run_op(op, '1, '0);
      run_op(op, $urandom, 32'd31);
      run_op(op, $urandom, 32'd32);
      run_op(op, $urandom, 32'd40);
      for (int i = 0; i < 20; i++) begin
        a = $urandom;
        b = $urandom;
        run_op(op, a, b);
      end
    end
    report_test("every opcode", start);

    // 4 in the result FIFO, 1 held by the executor, 4 in the command FIFO
    start = errors;
    for (int i = 0; i < 9; i++) begin
      a  = $urandom;
      b  = $urandom;
      op = alu_pkg::alu_op_e'($urandom_range(0, int'(alu_pkg::OP_CAT)));
      load_operands(a, b);
      issue_cmd(op, a, b);
    end
    wait_status_bit(0, 1'b1);      // cmd_full high
    apb_read(alu_pkg::REG_STATUS, data, err);
    check_flag("status.res_empty", data[1], 1'b0);
    check_data("status.count", {29'd0, data[6:4]}, 32'(alu_pkg::RES_DEPTH));
    apb_write(alu_pkg::REG_CMD, 32'd0, err);
    check_flag("pslverr", err, 1'b1);
    for (int i = 0; i < 9; i++) read_result();
    apb_read(alu_pkg::REG_RESULT, data, err);
    check_flag("pslverr", err, 1'b1);
    report_test("order and back-pressure", start);

    start = errors;
    apb_read(alu_pkg::REG_RESULT, data, err);
    check_flag("pslverr", err, 1'b1);
    check_data("prdata", data, '0);
    report_test("empty read", start);

    start = errors;
    load_operands(32'h1234_5678, 32'h0000_0003);
    apb_write(alu_pkg::REG_CMD, 32'd14, err);
    check_flag("pslverr", err, 1'b1);
    apb_write(alu_pkg::REG_CMD, 32'd15, err);
    check_flag("pslverr", err, 1'b1);
    apb_write(5'h14, 32'hdead_beef, err);
    check_flag("pslverr", err, 1'b1);
    apb_read(5'h1C, data, err);
    check_flag("pslverr", err, 1'b1);
    apb_read(alu_pkg::REG_STATUS, data, err);
    check_flag("status.res_empty", data[1], 1'b1);
    check_data("status.count", {29'd0, data[6:4]}, '0);
    report_test("invalid opcode and address", start);

    if (exp_q.size() != 0) begin
      $display("%0d expected results were never read back", exp_q.size());
      errors++;
    end
    $display("summary: 5 tests, %0d failed, %0d check errors", tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- alu_queue_top.sv
// top level of the APB operation queue
// APB port feeds the command FIFO, the executor drains it into the result FIFO
`timescale 1ns/1ps

module alu_queue_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [alu_pkg::ADDR_W-1:0]    paddr,
  input  logic [alu_pkg::DATA_W-1:0]    pwdata,
  output logic [alu_pkg::DATA_W-1:0]    prdata,
  output logic                          pready,
  output logic                          pslverr
);

  // command path
  logic                         cmd_push;
  logic [alu_pkg::CMD_W-1:0]    cmd_push_data;
  logic                         cmd_full;
  logic                         cmd_pop;
  logic [alu_pkg::CMD_W-1:0]    cmd_pop_data;
  logic                         cmd_empty;

  // result path
  logic                         res_push;
  logic [alu_pkg::DATA_W-1:0]   res_push_data;
  logic                         res_full;
  logic                         res_pop;
  logic [alu_pkg::DATA_W-1:0]   res_pop_data;
  logic                         res_empty;
  logic [alu_pkg::CNT_W-1:0]    res_count;

  apb_cmd_port port0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .cmd_push  (cmd_push),
    .cmd_data  (cmd_push_data),
    .cmd_full  (cmd_full),
    .res_pop   (res_pop),
    .res_data  (res_pop_data),
    .res_empty (res_empty),
    .res_count (res_count)
  );

  op_fifo #(.WIDTH(alu_pkg::CMD_W), .DEPTH(alu_pkg::CMD_DEPTH)) cmd_fifo0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (cmd_push),
    .push_data (cmd_push_data),
    .full      (cmd_full),
    .pop       (cmd_pop),
    .pop_data  (cmd_pop_data),
    .empty     (cmd_empty),
    .count     ()            // occupancy not reported for commands
  );

  alu_exec exec0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_pop   (cmd_pop),
    .cmd_data  (cmd_pop_data),
    .cmd_empty (cmd_empty),
    .res_push  (res_push),
    .res_data  (res_push_data),
    .res_full  (res_full)
  );

  op_fifo #(.WIDTH(alu_pkg::DATA_W), .DEPTH(alu_pkg::RES_DEPTH)) res_fifo0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (res_push),
    .push_data (res_push_data),
    .full      (res_full),
    .pop       (res_pop),
    .pop_data  (res_pop_data),
    .empty     (res_empty),
    .count     (res_count)
  );

endmodule

//--- alu_exec.sv
// executor for queued operations
// pops a command, applies one primitive, holds the result until the result FIFO takes it
`timescale 1ns/1ps

module alu_exec (
  input  logic                          clk,
  input  logic                          rst_n,
  // command FIFO pop side
  output logic                          cmd_pop,
  input  logic [alu_pkg::CMD_W-1:0]     cmd_data,
  input  logic                          cmd_empty,
  // result FIFO push side
  output logic                          res_push,
  output logic [alu_pkg::DATA_W-1:0]    res_data,
  input  logic                          res_full
);

  localparam int W = alu_pkg::DATA_W;
  localparam int H = alu_pkg::DATA_W / 2;

  logic [W-1:0]     left;
  logic [W-1:0]     right;
  alu_pkg::alu_op_e op;
  logic [W-1:0]     result;
  logic [W-1:0]     res_q;
  logic             valid_q;
  logic             can_load;

  // command word is {left, right, opcode}
  assign left  = cmd_data[alu_pkg::CMD_W-1 -: W];
  assign right = cmd_data[alu_pkg::OP_W +: W];
  assign op    = alu_pkg::alu_op_e'(cmd_data[alu_pkg::OP_W-1:0]);

  always_comb begin
    result = '0;
    case (op)
      alu_pkg::OP_AND: result = left & right;
      alu_pkg::OP_OR:  result = left | right;
      alu_pkg::OP_XOR: result = left ^ right;
      alu_pkg::OP_NOT: result = ~left;
      alu_pkg::OP_SUB: result = left - right;
      alu_pkg::OP_LSH: result = left << right; // amount >= 32 clears the word
      alu_pkg::OP_RSH: result = left >> right;
      // unsigned compares, one bit zero padded
      alu_pkg::OP_EQ:  result = {{(W-1){1'b0}}, left == right};
      alu_pkg::OP_NEQ: result = {{(W-1){1'b0}}, left != right};
      alu_pkg::OP_LT:  result = {{(W-1){1'b0}}, left < right};
      alu_pkg::OP_GT:  result = {{(W-1){1'b0}}, left > right};
      alu_pkg::OP_LE:  result = {{(W-1){1'b0}}, left <= right};
      alu_pkg::OP_GE:  result = {{(W-1){1'b0}}, left >= right};
      alu_pkg::OP_CAT: result = {left[H-1:0], right[H-1:0]};
      default:         result = '0;
    endcase
  end

  // output register frees up in the same cycle it drains
  assign res_push = valid_q & ~res_full;
  assign can_load = ~valid_q | res_push;
  assign cmd_pop  = ~cmd_empty & can_load;
  assign res_data = res_q;

  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      res_q <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (cmd_pop) begin
      valid_q <= 1'b1;
    end else if (res_push) begin
      valid_q <= 1'b0;
    end
  end

  // the port only queues opcodes that have an operator
  a_op_valid: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_pop |-> (cmd_data[alu_pkg::OP_W-1:0] <= alu_pkg::OP_CAT))
    else $error("alu_exec: popped command with an invalid opcode");

endmodule

//--- apb_cmd_port.sv
// APB slave for the operation queue
// holds operands, pushes command words, pops results and reports status
`timescale 1ns/1ps

module apb_cmd_port (
  input  logic                            clk,
  input  logic                            rst_n,
  // APB
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [alu_pkg::ADDR_W-1:0]      paddr,
  input  logic [alu_pkg::DATA_W-1:0]      pwdata,
  output logic [alu_pkg::DATA_W-1:0]      prdata,
  output logic                            pready,
  output logic                            pslverr,
  // command FIFO push side
  output logic                            cmd_push,
  output logic [alu_pkg::CMD_W-1:0]       cmd_data,
  input  logic                            cmd_full,
  // result FIFO pop side
  output logic                            res_pop,
  input  logic [alu_pkg::DATA_W-1:0]      res_data,
  input  logic                            res_empty,
  input  logic [alu_pkg::CNT_W-1:0]       res_count
);

  logic                         access;
  logic                         wr_en;
  logic                         rd_en;
  logic                         op_ok;
  logic                         err;
  logic [alu_pkg::DATA_W-1:0]   rd_data;
  logic [alu_pkg::DATA_W-1:0]   status;
  logic [alu_pkg::DATA_W-1:0]   left_q;
  logic [alu_pkg::DATA_W-1:0]   right_q;

  assign access = psel & penable; // access phase, always single cycle
  assign wr_en  = access & pwrite;
  assign rd_en  = access & ~pwrite;
  assign pready = 1'b1;

  // codes above OP_CAT have no operator
  assign op_ok = (pwdata[alu_pkg::OP_W-1:0] <= alu_pkg::OP_CAT);

  assign status = {{(alu_pkg::DATA_W - 7){1'b0}}, res_count, 2'b00, res_empty, cmd_full};

  // register decode, err covers refusals and wrong-direction accesses
  always_comb begin
    rd_data = '0;
    err     = 1'b0;
    case (paddr)
      alu_pkg::REG_LEFT:   rd_data = left_q;
      alu_pkg::REG_RIGHT:  rd_data = right_q;
      alu_pkg::REG_CMD: begin
        if (!pwrite || cmd_full || !op_ok) begin
          err = 1'b1;
        end
      end
      alu_pkg::REG_STATUS: begin
        if (pwrite) err = 1'b1;
        else rd_data = status;
      end
      alu_pkg::REG_RESULT: begin
        if (pwrite || res_empty) err = 1'b1; // empty read returns zero
        else rd_data = res_data;
      end
      default: err = 1'b1;
    endcase
  end

  assign prdata  = rd_en ? rd_data : '0;
  assign pslverr = access & err;

  assign cmd_push = wr_en & (paddr == alu_pkg::REG_CMD) & ~err;
  assign cmd_data = {left_q, right_q, pwdata[alu_pkg::OP_W-1:0]};
  assign res_pop  = rd_en & (paddr == alu_pkg::REG_RESULT) & ~err;

  // operand registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      left_q  <= '0;
      right_q <= '0;
    end else if (wr_en) begin
      if (paddr == alu_pkg::REG_LEFT) left_q <= pwdata;
      if (paddr == alu_pkg::REG_RIGHT) right_q <= pwdata;
    end
  end

  // host protocol: access phase only inside a selected transfer
  a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel)
    else $error("apb_cmd_port: penable without psel");

endmodule

//--- op_fifo.sv
// synchronous first-word-fall-through FIFO with push/pop handshake
// ring buffer of registers, read and write pointers, occupancy count
`timescale 1ns/1ps

module op_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         push,
  input  logic [WIDTH-1:0]             push_data,
  output logic                         full,
  input  logic                         pop,
  output logic [WIDTH-1:0]             pop_data,
  output logic                         empty,
  output logic [$clog2(DEPTH+1)-1:0]   count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] cnt_q;

  assign full     = (cnt_q == CNT_W'(DEPTH));
  assign empty    = (cnt_q == '0);
  assign count    = cnt_q;
  assign pop_data = mem[rd_ptr]; // head word is visible while not empty

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q; // both or neither
      endcase
    end
  end

  // producer must honour full, consumer must honour empty
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else $error("op_fifo: push while full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
    else $error("op_fifo: pop while empty");

endmodule

//--- alu_pkg.sv
// shared definitions for the APB operation queue
// widths, FIFO depths, register map and opcode encoding

package alu_pkg;

  localparam int DATA_W = 32; // operand and result width
  localparam int ADDR_W = 5;  // APB address width
  localparam int OP_W   = 4;  // opcode field width

  // command word is {left, right, opcode}
  localparam int CMD_W = 2 * DATA_W + OP_W;

  localparam int CMD_DEPTH = 4;
  localparam int RES_DEPTH = 4;

  // result occupancy as reported in STATUS bits 6:4
  localparam int CNT_W = 3;

  // register map
  localparam logic [ADDR_W-1:0] REG_LEFT   = 5'h00;
  localparam logic [ADDR_W-1:0] REG_RIGHT  = 5'h04;
  localparam logic [ADDR_W-1:0] REG_CMD    = 5'h08; // write only, opcode in bits 3:0
  localparam logic [ADDR_W-1:0] REG_STATUS = 5'h0C;
  localparam logic [ADDR_W-1:0] REG_RESULT = 5'h10; // read pops the result FIFO

  // primitive operators, codes 14 and 15 are not valid
  typedef enum logic [OP_W-1:0] {
    OP_AND = 4'd0,
    OP_OR  = 4'd1,
    OP_XOR = 4'd2,
    OP_NOT = 4'd3,
    OP_SUB = 4'd4,
    OP_LSH = 4'd5,
    OP_RSH = 4'd6,
    OP_EQ  = 4'd7,
    OP_NEQ = 4'd8,
    OP_LT  = 4'd9,
    OP_GT  = 4'd10,
    OP_LE  = 4'd11,
    OP_GE  = 4'd12,
    OP_CAT = 4'd13
  } alu_op_e;

endpackage
